// File: include/ipRx_consts.svh
`ifndef IPRX_CONSTS_SVH
`define IPRX_CONSTS_SVH

// Ethernet layer
`define ETH_HDR_LEN 14
`define ETHERTYPE_IPV4 16'h0800

// IPv4 protocol numbers
`define IP_PROTO_TCP 8'd6
`define IP_PROTO_UDP 8'd17

// UDP layer
`define UDP_HDR_LEN 8

// Cycles from a payload byte in to the same byte out
`define L2_LAT 1
`define L3_LAT 4
`define L4_LAT 1
`define STACK_LAT (`L2_LAT + `L3_LAT + `L4_LAT)

`endif

// File: hw/netTypesPkg.sv
`include "ipRx_consts.svh"

package netTypesPkg;

	typedef logic [47:0] macAddrT;
	typedef logic [31:0] ipAddrT;
	typedef logic [15:0] udpPortT;

	typedef enum logic [7:0]
	{
		PROTO_TCP = `IP_PROTO_TCP,
		PROTO_UDP = `IP_PROTO_UDP
	} ipProtoT;

	// Wide enough to sum a full IPv4 header without losing carries
	typedef logic [23:0] csumAccT;
	typedef logic [15:0] csumT;

	// One's complement fold with end-around carry
	function automatic csumT foldSum(csumAccT acc);
		logic [16:0] partial;
		partial = {1'b0, acc[15:0]} + {9'b0, acc[23:16]};
		return partial[15:0] + {15'b0, partial[16]};
	endfunction

endpackage

// File: hw/streamPkg.sv
package streamPkg;

	// One byte of the MAC stream
	typedef logic [7:0] dataByteT;

	// Byte counts and length fields
	typedef logic [15:0] frameLenT;

	// Transport carried by the IPv4 frame
	typedef enum logic [1:0]
	{
		L4_NONE = 2'd0,
		L4_UDP = 2'd1,
		L4_TCP = 2'd2
	} l4KindT;

endpackage

// File: hw/frameL2.sv
`timescale 1ns/1ps
`include "ipRx_consts.svh"

module frameL2
(
	input logic Clk,
	input logic rstN,
	input logic sofIn,
	input logic eofIn,
	input logic valIn,
	input logic errIn,
	input streamPkg::dataByteT dataIn,
	input netTypesPkg::macAddrT localMac,
	output logic sofOut,
	output logic eofOut,
	output logic valOut,
	output logic errOut,
	output streamPkg::dataByteT dataOut,
	output netTypesPkg::macAddrT remoteMac
);
	import netTypesPkg::*;
	import streamPkg::*;

	// 0 is idle, 14 is the first payload byte, 15 the rest
	logic [3:0] hdrCnt;
	logic [3:0] idx;
	logic hdrByte;
	logic payIn;
	macAddrT macShift;
	dataByteT localByte;
	logic macHit;
	logic bcastHit;
	logic accept;
	dataByteT typeHi;
	macAddrT srcShift;

	assign idx = sofIn ? 4'd0 : hdrCnt;
	assign hdrByte = valIn && (sofIn || (hdrCnt != 4'd0 && hdrCnt < 4'(`ETH_HDR_LEN)));
	assign payIn = valIn && !sofIn && (hdrCnt >= 4'(`ETH_HDR_LEN));

	// Local MAC byte lined up with the current header byte
	assign macShift = localMac << {idx, 3'b000};
	assign localByte = macShift[47:40];

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			hdrCnt <= '0;
			macHit <= 1'b0;
			bcastHit <= 1'b0;
			accept <= 1'b0;
			sofOut <= 1'b0;
			eofOut <= 1'b0;
			valOut <= 1'b0;
			errOut <= 1'b0;
			remoteMac <= '0;
		end
		else
		begin
			if (valIn && eofIn)
				hdrCnt <= '0;
			else if (valIn && sofIn)
				hdrCnt <= 4'd1;
			else if (valIn && hdrCnt != 4'd0 && hdrCnt != 4'(`ETH_HDR_LEN + 1))
				hdrCnt <= hdrCnt + 4'd1;

			if (hdrByte)
			begin
				case (idx)
					4'd0:
					begin
						macHit <= (dataIn == localByte);
						bcastHit <= (dataIn == 8'hFF);
						accept <= 1'b0;
					end
					4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
					begin
						macHit <= macHit && (dataIn == localByte);
						bcastHit <= bcastHit && (dataIn == 8'hFF);
					end
					4'd13:
						accept <= (macHit || bcastHit) && ({typeHi, dataIn} == `ETHERTYPE_IPV4);
					default:
					begin
					end
				endcase
			end

			sofOut <= payIn && accept && (hdrCnt == 4'(`ETH_HDR_LEN));
			valOut <= payIn && accept;
			eofOut <= payIn && accept && eofIn;
			errOut <= payIn && accept && eofIn && errIn;

			if (payIn && accept && (hdrCnt == 4'(`ETH_HDR_LEN)))
				remoteMac <= srcShift;
		end
	end

	always_ff @(posedge Clk)
	begin
		dataOut <= dataIn;
		// Source MAC sits in bytes 6 to 11
		if (hdrByte && idx >= 4'd6 && idx <= 4'd11)
			srcShift <= {srcShift[39:0], dataIn};
		if (hdrByte && idx == 4'd12)
			typeHi <= dataIn;
	end

	// A new frame must not start inside the Ethernet header of the last one
	sofOutsideHeader: assert property (@(posedge Clk) disable iff (!rstN)
		(valIn && sofIn) |-> (hdrCnt == 4'd0 || hdrCnt >= 4'(`ETH_HDR_LEN)))
		else $error("frameL2: sof inside Ethernet header");

endmodule

// File: hw/frameL3.sv
`timescale 1ns/1ps

module frameL3
(
	input logic Clk,
	input logic rstN,
	input logic sofIn,
	input logic eofIn,
	input logic valIn,
	input logic errIn,
	input streamPkg::dataByteT dataIn,
	input netTypesPkg::ipAddrT localIp,
	input netTypesPkg::macAddrT remoteMacIn,
	output logic sofOut,
	output logic eofOut,
	output logic valOut,
	output logic errOut,
	output streamPkg::dataByteT dataOut,
	output logic frameOut,
	output netTypesPkg::macAddrT remoteMacOut,
	output netTypesPkg::ipAddrT remoteIp,
	output netTypesPkg::csumAccT pseudoSum,
	output logic isUdp,
	output logic isTcp
);
	import netTypesPkg::*;
	import streamPkg::*;

	frameLenT byteCnt;
	frameLenT idx;
	frameLenT totalLen;
	logic [5:0] hdrLen;
	logic inFrame;
	logic hdrByte;
	logic payIn;
	dataByteT prevByte;
	logic [15:0] inWord;
	csumAccT hdrAcc;
	csumAccT pAcc;
	ipAddrT srcShift;
	l4KindT l4Kind;
	logic ipHit;
	logic ipOk;
	logic csumBad;
	logic lenBad;

	// Input register plus two delay stages
	logic [2:0] sofD;
	logic [2:0] eofD;
	logic [2:0] valD;
	logic [2:0] errD;
	dataByteT dataD [3];

	assign idx = sofIn ? '0 : byteCnt;
	assign hdrByte = valIn && (sofIn || (inFrame && byteCnt < frameLenT'(hdrLen)));
	assign payIn = valIn && !sofIn && inFrame && (byteCnt >= frameLenT'(hdrLen));
	assign inWord = {prevByte, dataIn};

	// Checked while the eof beat sits in the input register
	assign csumBad = (foldSum(hdrAcc) != 16'hFFFF);
	assign lenBad = (byteCnt != totalLen);

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			byteCnt <= '0;
			hdrLen <= '0;
			inFrame <= 1'b0;
			hdrAcc <= '0;
			pAcc <= '0;
			totalLen <= '0;
			l4Kind <= L4_NONE;
			ipHit <= 1'b0;
			ipOk <= 1'b0;
			sofD <= '0;
			eofD <= '0;
			valD <= '0;
			errD <= '0;
			sofOut <= 1'b0;
			eofOut <= 1'b0;
			valOut <= 1'b0;
			errOut <= 1'b0;
			frameOut <= 1'b0;
			remoteMacOut <= '0;
			remoteIp <= '0;
			pseudoSum <= '0;
			isUdp <= 1'b0;
			isTcp <= 1'b0;
		end
		else
		begin
			if (valIn && sofIn)
			begin
				byteCnt <= 16'd1;
				hdrLen <= {dataIn[3:0], 2'b00};
				hdrAcc <= '0;
				// Pseudo-header starts at minus the header length
				pAcc <= -csumAccT'({dataIn[3:0], 2'b00});
			end
			else if (valIn)
				byteCnt <= byteCnt + 16'd1;

			if (valIn && eofIn)
				inFrame <= 1'b0;
			else if (valIn && sofIn)
				inFrame <= 1'b1;

			// Header words end on odd byte offsets
			if (hdrByte && idx[0])
				hdrAcc <= hdrAcc + csumAccT'(inWord);

			if (hdrByte)
			begin
				case (idx)
					16'd3:
					begin
						totalLen <= inWord;
						pAcc <= pAcc + csumAccT'(inWord);
					end
					16'd9:
					begin
						l4Kind <= (dataIn == PROTO_UDP) ? L4_UDP :
							(dataIn == PROTO_TCP) ? L4_TCP : L4_NONE;
						pAcc <= pAcc + csumAccT'(dataIn);
					end
					16'd13, 16'd15:
						pAcc <= pAcc + csumAccT'(inWord);
					16'd16:
						ipHit <= (dataIn == localIp[31:24]);
					16'd17:
					begin
						pAcc <= pAcc + csumAccT'(inWord);
						ipHit <= ipHit && (dataIn == localIp[23:16]);
					end
					16'd18:
						ipHit <= ipHit && (dataIn == localIp[15:8]);
					16'd19:
					begin
						pAcc <= pAcc + csumAccT'(inWord);
						// Subnet broadcast also accepted
						ipOk <= ipHit && (dataIn == localIp[7:0] || dataIn == 8'hFF);
					end
					default:
					begin
					end
				endcase
			end

			sofD <= {sofD[1:0], payIn && (byteCnt == frameLenT'(hdrLen))};
			valD <= {valD[1:0], payIn};
			eofD <= {eofD[1:0], payIn && eofIn};
			errD[0] <= payIn && eofIn && errIn;
			errD[1] <= errD[0] || (eofD[0] && (lenBad || csumBad));
			errD[2] <= errD[1];

			// Output stage gated by the IP match
			sofOut <= sofD[2] && ipOk;
			valOut <= valD[2] && ipOk;
			eofOut <= eofD[2] && ipOk;
			errOut <= errD[2] && ipOk;

			if (sofD[2] && ipOk)
			begin
				frameOut <= 1'b1;
				remoteMacOut <= remoteMacIn;
				remoteIp <= srcShift;
				pseudoSum <= pAcc;
				isUdp <= (l4Kind == L4_UDP);
				isTcp <= (l4Kind == L4_TCP);
			end
			else if (eofOut)
				frameOut <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (valIn)
			prevByte <= dataIn;
		if (hdrByte && idx >= 16'd12 && idx <= 16'd15)
			srcShift <= {srcShift[23:0], dataIn};
		dataD[0] <= dataIn;
		dataD[1] <= dataD[0];
		dataD[2] <= dataD[1];
		dataOut <= dataD[2];
	end

	// Payload beats only inside an accepted frame
	valInsideFrame: assert property (@(posedge Clk) disable iff (!rstN)
		valOut |-> frameOut)
		else $error("frameL3: valOut outside frame");

endmodule

// File: hw/frameL4Udp.sv
`timescale 1ns/1ps
`include "ipRx_consts.svh"

module frameL4Udp
(
	input logic Clk,
	input logic rstN,
	input logic sofIn,
	input logic eofIn,
	input logic valIn,
	input logic errIn,
	input streamPkg::dataByteT dataIn,
	input logic isUdp,
	input netTypesPkg::csumAccT pseudoSum,
	input netTypesPkg::udpPortT localPort,
	output logic sofOut,
	output logic eofOut,
	output logic valOut,
	output logic errOut,
	output streamPkg::dataByteT dataOut,
	output netTypesPkg::udpPortT remotePort,
	output streamPkg::frameLenT udpLen
);
	import netTypesPkg::*;
	import streamPkg::*;

	// 0 is idle, 8 is the first payload byte, 9 the rest
	logic [3:0] hdrCnt;
	logic byteOdd;
	logic oddNow;
	logic payIn;
	logic firstPay;
	logic accept;
	dataByteT prevByte;
	logic [15:0] inWord;
	logic [15:0] addWord;
	csumT acc;
	csumT accNext;
	csumT csumTx;
	udpPortT srcPort;
	frameLenT lenReg;
	logic csumBad;

	assign oddNow = !sofIn && byteOdd;
	assign inWord = {prevByte, dataIn};
	assign payIn = valIn && !sofIn && (hdrCnt >= 4'(`UDP_HDR_LEN));
	assign firstPay = (hdrCnt == 4'(`UDP_HDR_LEN));

	// Odd trailing byte is padded with zero
	assign addWord = oddNow ? inWord : (eofIn ? {dataIn, 8'h00} : 16'h0000);
	assign accNext = foldSum(csumAccT'(acc) + csumAccT'(addWord));

	// Zero on the wire means the sender skipped the checksum
	assign csumBad = (csumTx != '0) && (accNext != 16'hFFFF);

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			hdrCnt <= '0;
			byteOdd <= 1'b0;
			accept <= 1'b0;
			acc <= '0;
			csumTx <= '0;
			sofOut <= 1'b0;
			eofOut <= 1'b0;
			valOut <= 1'b0;
			errOut <= 1'b0;
			remotePort <= '0;
			udpLen <= '0;
		end
		else
		begin
			if (valIn && eofIn)
				hdrCnt <= '0;
			else if (valIn && sofIn)
				hdrCnt <= 4'd1;
			else if (valIn && hdrCnt != 4'd0 && hdrCnt != 4'(`UDP_HDR_LEN + 1))
				hdrCnt <= hdrCnt + 4'd1;

			if (valIn)
			begin
				byteOdd <= sofIn ? 1'b1 : !byteOdd;
				acc <= sofIn ? foldSum(pseudoSum) : accNext;
			end

			if (valIn && sofIn)
				accept <= 1'b0;
			else if (valIn && hdrCnt == 4'd3)
				accept <= isUdp && (inWord == localPort);

			if (valIn && !sofIn && hdrCnt == 4'd7)
				csumTx <= inWord;

			sofOut <= payIn && accept && firstPay;
			valOut <= payIn && accept;
			eofOut <= payIn && accept && eofIn;
			errOut <= payIn && accept && eofIn && (errIn || csumBad);

			if (payIn && accept && firstPay)
			begin
				remotePort <= srcPort;
				udpLen <= lenReg;
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		if (valIn)
			prevByte <= dataIn;
		if (valIn && !sofIn && hdrCnt == 4'd1)
			srcPort <= inWord;
		if (valIn && !sofIn && hdrCnt == 4'd5)
			lenReg <= inWord;
		dataOut <= dataIn;
	end

	// A new datagram starts only after the last one ended
	sofBetweenFrames: assert property (@(posedge Clk) disable iff (!rstN)
		(valIn && sofIn) |-> (hdrCnt == 4'd0))
		else $error("frameL4Udp: sof inside a datagram");

endmodule

// File: hw/ipRxStack.sv
`timescale 1ns/1ps

module ipRxStack
(
	input logic Clk,
	input logic rstN,
	input logic sofIn,
	input logic eofIn,
	input logic valIn,
	input logic errIn,
	input streamPkg::dataByteT dataIn,
	input netTypesPkg::macAddrT localMac,
	input netTypesPkg::ipAddrT localIp,
	input netTypesPkg::udpPortT localPort,
	output logic sofOut,
	output logic eofOut,
	output logic valOut,
	output logic errOut,
	output streamPkg::dataByteT dataOut,
	output netTypesPkg::macAddrT remoteMac,
	output netTypesPkg::ipAddrT remoteIp,
	output netTypesPkg::udpPortT remotePort,
	output streamPkg::frameLenT udpLen
);
	import netTypesPkg::*;
	import streamPkg::*;

	// Ethernet to IPv4
	logic l2Sof;
	logic l2Eof;
	logic l2Val;
	logic l2Err;
	dataByteT l2Data;
	macAddrT l2Mac;

	// IPv4 to UDP
	logic l3Sof;
	logic l3Eof;
	logic l3Val;
	logic l3Err;
	dataByteT l3Data;
	logic l3IsUdp;
	csumAccT l3PseudoSum;

	frameL2 l2_i
	(
		.Clk(Clk),
		.rstN(rstN),
		.sofIn(sofIn),
		.eofIn(eofIn),
		.valIn(valIn),
		.errIn(errIn),
		.dataIn(dataIn),
		.localMac(localMac),
		.sofOut(l2Sof),
		.eofOut(l2Eof),
		.valOut(l2Val),
		.errOut(l2Err),
		.dataOut(l2Data),
		.remoteMac(l2Mac)
	);

	frameL3 l3_i
	(
		.Clk(Clk),
		.rstN(rstN),
		.sofIn(l2Sof),
		.eofIn(l2Eof),
		.valIn(l2Val),
		.errIn(l2Err),
		.dataIn(l2Data),
		.localIp(localIp),
		.remoteMacIn(l2Mac),
		.sofOut(l3Sof),
		.eofOut(l3Eof),
		.valOut(l3Val),
		.errOut(l3Err),
		.dataOut(l3Data),
		.frameOut(),
		.remoteMacOut(remoteMac),
		.remoteIp(remoteIp),
		.pseudoSum(l3PseudoSum),
		.isUdp(l3IsUdp),
		.isTcp()
	);

	// TCP frames end here since only UDP passes layer 4
	frameL4Udp l4_i
	(
		.Clk(Clk),
		.rstN(rstN),
		.sofIn(l3Sof),
		.eofIn(l3Eof),
		.valIn(l3Val),
		.errIn(l3Err),
		.dataIn(l3Data),
		.isUdp(l3IsUdp),
		.pseudoSum(l3PseudoSum),
		.localPort(localPort),
		.sofOut(sofOut),
		.eofOut(eofOut),
		.valOut(valOut),
		.errOut(errOut),
		.dataOut(dataOut),
		.remotePort(remotePort),
		.udpLen(udpLen)
	);

endmodule

// File: test/ipRxRefPkg.sv
package ipRxRefPkg;

	import netTypesPkg::*;
	import streamPkg::*;

	// Header fields and corruptions of one test frame
	typedef struct packed {
		macAddrT dstMac;
		macAddrT srcMac;
		logic [15:0] etherType;
		logic [3:0] ihl;
		frameLenT lenAdj;
		logic [7:0] proto;
		ipAddrT srcIp;
		ipAddrT dstIp;
		logic badIpCsum;
		udpPortT srcPort;
		udpPortT dstPort;
		// 0 correct, 1 zero, 2 wrong
		logic [1:0] udpMode;
	} frameCfgT;

	typedef struct packed {
		logic accept;
		logic err;
		frameLenT payStart;
		macAddrT mac;
		ipAddrT ip;
		udpPortT port;
		frameLenT len;
	} refResultT;

	// Adds bytes as big-endian 16-bit words, odd tail padded with zero
	function automatic logic [31:0] addBytes(logic [31:0] acc, input dataByteT q[$],
		int first, int count);
		for (int i = 0; i < count; i += 2)
			acc += {16'h0, q[first + i], (i + 1 < count) ? q[first + i + 1] : 8'h00};
		return acc;
	endfunction

	function automatic csumT fold32(logic [31:0] s);
		while (s[31:16] != 16'h0)
			s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
		return s[15:0];
	endfunction

	function automatic void buildFrame(input frameCfgT c, input dataByteT pay[$],
		output dataByteT f[$]);
		dataByteT ip[$];
		dataByteT udp[$];
		int hl;
		frameLenT tl;
		frameLenT ulen;
		csumT ck;
		logic [31:0] s;
		hl = int'(c.ihl) * 4;
		ulen = frameLenT'(8 + pay.size());
		tl = frameLenT'(hl) + ulen + c.lenAdj;
		ip = '{{4'h4, c.ihl}, 8'h00, tl[15:8], tl[7:0], 8'h00, 8'h00, 8'h40, 8'h00,
			8'h40, c.proto, 8'h00, 8'h00,
			c.srcIp[31:24], c.srcIp[23:16], c.srcIp[15:8], c.srcIp[7:0],
			c.dstIp[31:24], c.dstIp[23:16], c.dstIp[15:8], c.dstIp[7:0]};
		// Option bytes
		for (int i = 20; i < hl; i++)
			ip.push_back(8'hA0 + 8'(i));
		ck = ~fold32(addBytes(32'h0, ip, 0, hl));
		if (c.badIpCsum)
			ck ^= 16'h0001;
		ip[10] = ck[15:8];
		ip[11] = ck[7:0];
		udp = '{c.srcPort[15:8], c.srcPort[7:0], c.dstPort[15:8], c.dstPort[7:0],
			ulen[15:8], ulen[7:0], 8'h00, 8'h00};
		foreach (pay[i])
			udp.push_back(pay[i]);
		s = 32'(ulen) + 32'(c.proto);
		s = addBytes(s, ip, 12, 8);
		s = addBytes(s, udp, 0, udp.size());
		ck = ~fold32(s);
		if (ck == 16'h0)
			ck = 16'hFFFF;
		if (c.udpMode == 2'd1)
			ck = 16'h0;
		else if (c.udpMode == 2'd2)
			ck ^= 16'h0100;
		udp[6] = ck[15:8];
		udp[7] = ck[7:0];
		f = '{c.dstMac[47:40], c.dstMac[39:32], c.dstMac[31:24], c.dstMac[23:16],
			c.dstMac[15:8], c.dstMac[7:0], c.srcMac[47:40], c.srcMac[39:32],
			c.srcMac[31:24], c.srcMac[23:16], c.srcMac[15:8], c.srcMac[7:0],
			c.etherType[15:8], c.etherType[7:0]};
		foreach (ip[i])
			f.push_back(ip[i]);
		foreach (udp[i])
			f.push_back(udp[i]);
	endfunction

	// Expected delivery, metadata and eof error of one frame on the wire
	function automatic refResultT refModel(input dataByteT f[$], macAddrT lMac,
		ipAddrT lIp, udpPortT lPort, logic errIn);
		refResultT r;
		macAddrT dst;
		ipAddrT dIp;
		int hl;
		int u;
		frameLenT tl;
		logic l2Ok;
		logic ipOk;
		logic ipBad;
		logic lenBad;
		logic udpBad;
		logic [31:0] s;
		csumT tx;
		dst = {f[0], f[1], f[2], f[3], f[4], f[5]};
		r.mac = {f[6], f[7], f[8], f[9], f[10], f[11]};
		l2Ok = (dst == lMac || dst == '1) && ({f[12], f[13]} == 16'h0800);
		hl = int'(f[14][3:0]) * 4;
		u = 14 + hl;
		tl = {f[16], f[17]};
		r.ip = {f[26], f[27], f[28], f[29]};
		dIp = {f[30], f[31], f[32], f[33]};
		// Subnet broadcast shares the first three bytes
		ipOk = (dIp[31:8] == lIp[31:8]) && (dIp[7:0] == lIp[7:0] || dIp[7:0] == 8'hFF);
		ipBad = fold32(addBytes(32'h0, f, 14, hl)) != 16'hFFFF;
		lenBad = (f.size() - 14) != int'(tl);
		r.port = {f[u], f[u + 1]};
		r.len = {f[u + 4], f[u + 5]};
		tx = {f[u + 6], f[u + 7]};
		// Pseudo-header length taken from total length minus header length
		s = 32'(tl) - 32'(hl) + 32'(f[23]);
		s = addBytes(s, f, 26, 8);
		s = addBytes(s, f, u, f.size() - u);
		udpBad = (tx != 16'h0) && (fold32(s) != 16'hFFFF);
		r.accept = l2Ok && ipOk && (f[23] == 8'd17) && ({f[u + 2], f[u + 3]} == lPort)
			&& (f.size() > u + 8);
		r.err = errIn || ipBad || lenBad || udpBad;
		r.payStart = frameLenT'(u + 8);
		return r;
	endfunction

endpackage

// File: test/ipRxStackTb.sv
`timescale 1ns/1ps
`include "ipRx_consts.svh"

module ipRxStackTb;
	import netTypesPkg::*;
	import streamPkg::*;
	import ipRxRefPkg::*;

	typedef struct packed {
		logic [31:0] cyc;
		dataByteT data;
		logic sof;
		logic eof;
		logic err;
		macAddrT mac;
		ipAddrT ip;
		udpPortT port;
		frameLenT len;
	} expBeatT;

	localparam macAddrT myMac = 48'h02_11_22_33_44_55;
	localparam ipAddrT myIp = 32'hC0_A8_01_0A;
	localparam udpPortT myPort = 16'd5005;

	logic Clk;
	logic rstN;
	logic sofIn;
	logic eofIn;
	logic valIn;
	logic errIn;
	dataByteT dataIn;
	macAddrT localMac;
	ipAddrT localIp;
	udpPortT localPort;
	logic sofOut;
	logic eofOut;
	logic valOut;
	logic errOut;
	dataByteT dataOut;
	macAddrT remoteMac;
	ipAddrT remoteIp;
	udpPortT remotePort;
	frameLenT udpLen;

	integer seed;
	logic [31:0] cyc;
	expBeatT expQ[$];
	expBeatT e;
	frameCfgT cfg;

	ipRxStack dut_i
	(
		.Clk(Clk),
		.rstN(rstN),
		.sofIn(sofIn),
		.eofIn(eofIn),
		.valIn(valIn),
		.errIn(errIn),
		.dataIn(dataIn),
		.localMac(localMac),
		.localIp(localIp),
		.localPort(localPort),
		.sofOut(sofOut),
		.eofOut(eofOut),
		.valOut(valOut),
		.errOut(errOut),
		.dataOut(dataOut),
		.remoteMac(remoteMac),
		.remoteIp(remoteIp),
		.remotePort(remotePort),
		.udpLen(udpLen)
	);

	initial
	begin
		Clk = 1'b0;
		forever
			#4 Clk = ~Clk;
	end

	task automatic reportFail(string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkByte(string name, dataByteT got, dataByteT exp);
		if (got !== exp)
			reportFail($sformatf("Error at %0d ns: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkMac(string name, macAddrT got, macAddrT exp);
		if (got !== exp)
			reportFail($sformatf("Error at %0d ns: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkIp(string name, ipAddrT got, ipAddrT exp);
		if (got !== exp)
			reportFail($sformatf("Error at %0d ns: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkPort(string name, udpPortT got, udpPortT exp);
		if (got !== exp)
			reportFail($sformatf("Error at %0d ns: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkLen(string name, frameLenT got, frameLenT exp);
		if (got !== exp)
			reportFail($sformatf("Error at %0d ns: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
			reportFail($sformatf("Error at %0d ns: %s got %b expected %b", $time, name, got, exp));
	endtask

	// Outputs sampled at the falling edge
	always @(negedge Clk)
	begin
		cyc = cyc + 1;
		if (rstN && valOut)
		begin
			if (expQ.size() == 0)
				reportFail($sformatf("Output beat at %0d ns where no beat was expected", $time));
			else
			begin
				e = expQ.pop_front();
				if (e.cyc != cyc)
					reportFail($sformatf("Output beat at cycle %0d, expected at cycle %0d",
						cyc, e.cyc));
				else
				begin
					checkByte("dataOut", dataOut, e.data);
					checkBit("sofOut", sofOut, e.sof);
					checkBit("eofOut", eofOut, e.eof);
					checkBit("errOut", errOut, e.err);
					if (e.sof)
					begin
						checkMac("remoteMac", remoteMac, e.mac);
						checkIp("remoteIp", remoteIp, e.ip);
						checkPort("remotePort", remotePort, e.port);
						checkLen("udpLen", udpLen, e.len);
					end
				end
			end
		end
	end

	function automatic frameCfgT goodCfg();
		frameCfgT c;
		c.dstMac = myMac;
		c.srcMac = 48'h0A_BC_DE_F0_12_34;
		c.etherType = `ETHERTYPE_IPV4;
		c.ihl = 4'd5;
		c.lenAdj = '0;
		c.proto = `IP_PROTO_UDP;
		c.srcIp = 32'hC0_A8_01_63;
		c.dstIp = myIp;
		c.badIpCsum = 1'b0;
		c.srcPort = 16'd40000;
		c.dstPort = myPort;
		c.udpMode = 2'd0;
		return c;
	endfunction

	// Builds, predicts and drives one frame, then idles a random gap
	task automatic sendFrame(frameCfgT c, int payLen, logic errFlag);
		dataByteT pay[$];
		dataByteT f[$];
		refResultT r;
		expBeatT x;
		int gap;
		for (int i = 0; i < payLen; i++)
			pay.push_back(dataByteT'($random(seed)));
		buildFrame(c, pay, f);
		r = refModel(f, myMac, myIp, myPort, errFlag);
		for (int i = 0; i < f.size(); i++)
		begin
			@(posedge Clk);
			sofIn <= (i == 0);
			eofIn <= (i == f.size() - 1);
			valIn <= 1'b1;
			errIn <= errFlag && (i == f.size() - 1);
			dataIn <= f[i];
			if (r.accept && i >= int'(r.payStart))
			begin
				// Byte is on the inputs from the next falling edge
				x.cyc = cyc + 1 + `STACK_LAT;
				x.data = f[i];
				x.sof = (i == int'(r.payStart));
				x.eof = (i == f.size() - 1);
				x.err = x.eof && r.err;
				x.mac = r.mac;
				x.ip = r.ip;
				x.port = r.port;
				x.len = r.len;
				expQ.push_back(x);
			end
		end
		@(posedge Clk);
		sofIn <= 1'b0;
		eofIn <= 1'b0;
		valIn <= 1'b0;
		errIn <= 1'b0;
		gap = 1 + int'($unsigned($random(seed)) % 6);
		repeat (gap) @(posedge Clk);
	endtask

	initial
	begin
		int kind;
		int wait0;
		seed = 32'h1c6f7e7f;
		cyc = '0;
		rstN = 1'b0;
		sofIn = 1'b0;
		eofIn = 1'b0;
		valIn = 1'b0;
		errIn = 1'b0;
		dataIn = '0;
		localMac = myMac;
		localIp = myIp;
		localPort = myPort;
		repeat (4) @(posedge Clk);
		rstN <= 1'b1;
		@(posedge Clk);

		// Plain good frame
		sendFrame(goodCfg(), 10, 1'b0);

		// Filtered frames
		cfg = goodCfg();
		cfg.dstMac = myMac ^ 48'h1;
		sendFrame(cfg, 6, 1'b0);
		cfg = goodCfg();
		cfg.etherType = 16'h0806;
		sendFrame(cfg, 6, 1'b0);
		cfg = goodCfg();
		cfg.dstIp = myIp ^ 32'h100;
		sendFrame(cfg, 6, 1'b0);
		cfg = goodCfg();
		cfg.proto = `IP_PROTO_TCP;
		sendFrame(cfg, 6, 1'b0);
		cfg = goodCfg();
		cfg.dstPort = myPort + 16'd1;
		sendFrame(cfg, 6, 1'b0);

		// Broadcast MAC, subnet broadcast IP and IPv4 options
		cfg = goodCfg();
		cfg.dstMac = '1;
		sendFrame(cfg, 7, 1'b0);
		cfg = goodCfg();
		cfg.dstIp = {myIp[31:8], 8'hFF};
		sendFrame(cfg, 8, 1'b0);
		cfg = goodCfg();
		cfg.ihl = 4'd6;
		sendFrame(cfg, 9, 1'b0);

		// Errors flagged at eof
		cfg = goodCfg();
		cfg.badIpCsum = 1'b1;
		sendFrame(cfg, 5, 1'b0);
		cfg = goodCfg();
		cfg.lenAdj = 16'd2;
		sendFrame(cfg, 5, 1'b0);
		sendFrame(goodCfg(), 5, 1'b1);
		cfg = goodCfg();
		cfg.udpMode = 2'd2;
		sendFrame(cfg, 11, 1'b0);
		cfg = goodCfg();
		cfg.udpMode = 2'd1;
		sendFrame(cfg, 11, 1'b0);

		// Mixed random traffic
		for (int n = 0; n < 40; n++)
		begin
			cfg = goodCfg();
			cfg.srcPort = udpPortT'($random(seed));
			kind = int'($unsigned($random(seed)) % 8);
			case (kind)
				3: cfg.badIpCsum = 1'b1;
				4: cfg.udpMode = 2'd2;
				5: cfg.dstPort = myPort ^ 16'h0040;
				6: cfg.ihl = 4'd6;
				7: cfg.lenAdj = 16'd1;
				default:
				begin
				end
			endcase
			sendFrame(cfg, 1 + int'($unsigned($random(seed)) % 20), kind == 2);
		end

		wait0 = 0;
		while (expQ.size() != 0 && wait0 < 200)
		begin
			@(posedge Clk);
			wait0++;
		end
		// Window for stray beats
		repeat (16) @(posedge Clk);
		if (expQ.size() != 0)
			reportFail("Timed out waiting for expected payload beats");
		else
		begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: ipRxStack.f
+incdir+include
hw/netTypesPkg.sv
hw/streamPkg.sv
hw/frameL2.sv
hw/frameL3.sv
hw/frameL4Udp.sv
hw/ipRxStack.sv
test/ipRxRefPkg.sv
test/ipRxStackTb.sv

// File: run.sh
#!/bin/sh
# Build and run the ipRxStack testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module ipRxStackTb -f ipRxStack.f -Mdir obj_dir -o ipRxStackSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/ipRxStackSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

exit 0
